/* verilog.f */
n64_video_pkg.sv
n64_vdemux.sv
n64_vinfo_ext.sv
n64_pixel_fifo.sv
n64_vout_fmt.sv
n64_video_top.sv
tb_n64_video_chk.sv
tb_n64_video.sv

/* tb_n64_video.sv */
// testbench for the n64 video path: drives bus frames, models pixels and vinfo, checks outputs
`timescale 1ns/1ps

module tb_n64_video;

  import n64_video_pkg::*;

  localparam int PIXELS_PER_LINE = 12;
  localparam int LINE_CYCLES     = PIXELS_PER_LINE * 4;
  // 13 fields of 5 lines, 2 of 7, 3 overflow lines, reset, quiet gap, drain allowance
  localparam int PLANNED_CYCLES  = (13 * 5 + 2 * 7 + 3) * LINE_CYCLES + 8 + 20 + 16 * 40;
  localparam int TIMEOUT_CYCLES  = 2 * PLANNED_CYCLES;

  logic       VCLK;
  logic       nRST;
  logic       nVDSYNC;
  n64_data_t  d;
  out_pixel_t out_pix;
  logic       out_valid;
  logic       out_ready;
  vinfo_t     vinfo;
  logic       overflow;

  integer     seed;
  int         cycle_cnt;
  string      cur_test;
  logic       hold_ready;
  // dropped pixels expected, outputs only need to keep model order
  logic       lossy;

  // expected output stream
  out_pixel_t exp_q[$];

  // model of the extractor and formatter state
  sync_t      m_pre;
  sync_t      m_cur;
  logic       m_field;
  logic [1:0] m_lcnt;
  vinfo_t     m_vinfo;
  logic       m_prev_hs;
  hpos_t      m_hpos;

  n64_video_top n64_video_top_inst (
    .VCLK      (VCLK),
    .nRST      (nRST),
    .nVDSYNC   (nVDSYNC),
    .d         (d),
    .out_pix   (out_pix),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .vinfo     (vinfo),
    .overflow  (overflow)
  );

  initial begin
    VCLK = 1'b0;
    forever #5 VCLK = ~VCLK;
  end

  // ============================================================
  // failure reporting and compare tasks
  // ============================================================

  task automatic stop_with_failure();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_pixel(input string tname, input out_pixel_t exp, input out_pixel_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", tname, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_vinfo(input string tname, input vinfo_t exp, input vinfo_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %b, actual %b", tname, exp, act);
      stop_with_failure();
    end
  endtask

  // ============================================================
  // reference model
  // ============================================================

  // one sync nibble through the presence, parity and line count rules
  task automatic update_sync_model(input sync_t s);
    logic vf;
    logic hf;
    m_pre = m_cur;
    m_cur = s;
    vf = m_pre.nvsync && !m_cur.nvsync;
    hf = m_pre.nhsync && !m_cur.nhsync;
    if (vf && hf)
      m_vinfo.vdata_detected = 1'b1;
    if (vf) begin
      m_vinfo.n64_480i = m_field ^ hf;
      m_field          = hf;
      m_vinfo.palmode  = ~m_lcnt[1];
      m_lcnt           = 2'b00;
    end else if (hf) begin
      m_lcnt = m_lcnt + 2'd1;
    end
  endtask

  // ============================================================
  // bus stimulus
  // ============================================================

  // one vclk beat, driven just after the rising edge, sink ready about 70%
  task automatic drive_beat(input logic vds, input n64_data_t beat);
    @(posedge VCLK);
    #1;
    nVDSYNC = vds;
    d       = beat;
    if (hold_ready)
      out_ready = 1'b0;
    else
      out_ready = ((($random(seed) & 32'h7fff_ffff) % 10) < 7);
  endtask

  task automatic send_pixel(input sync_t s);
    logic [31:0] rnd;
    color_t      r;
    color_t      g;
    color_t      b;
    out_pixel_t  e;
    rnd = $random(seed);
    r   = rnd[6:0];
    g   = rnd[13:7];
    b   = rnd[20:14];
    update_sync_model(s);
    e.pix.sync = s;
    // blanked unless video was seen by this pixel's sync beat
    e.pix.red   = m_vinfo.vdata_detected ? r : '0;
    e.pix.green = m_vinfo.vdata_detected ? g : '0;
    e.pix.blue  = m_vinfo.vdata_detected ? b : '0;
    if (m_prev_hs && !s.nhsync)
      m_hpos = '0;
    else if (m_hpos != '1)
      m_hpos = m_hpos + 1'b1;
    m_prev_hs = s.nhsync;
    e.hpos    = m_hpos;
    exp_q.push_back(e);
    drive_beat(1'b0, {3'b000, s});
    drive_beat(1'b1, r);
    drive_beat(1'b1, g);
    drive_beat(1'b1, b);
  endtask

  // hsync low on pixel 0, vsync low from vs_start to the end of a vsync line
  task automatic send_line(input logic vs_line, input int vs_start);
    sync_t s;
    for (int p = 0; p < PIXELS_PER_LINE; p++) begin
      s.nvsync = !(vs_line && p >= vs_start);
      s.nclamp = (p != 1);
      s.nhsync = (p != 0);
      s.ncsync = s.nvsync && s.nhsync;
      send_pixel(s);
    end
  endtask

  // repeat the last sync nibble until every expected pixel came out
  task automatic drain_pipeline(input string tname);
    int n;
    n = 0;
    while (n < 3 || exp_q.size() != 0) begin
      drive_beat(1'b0, {3'b000, m_cur});
      n++;
    end
    check_vinfo(tname, m_vinfo, vinfo);
  endtask

  // vsync on pixel 0 together with hsync, or mid-line at pixel 6
  task automatic send_field(input string tname, input int lines, input logic vs_with_hs);
    cur_test = tname;
    send_line(1'b1, vs_with_hs ? 0 : 6);
    for (int ln = 1; ln < lines; ln++)
      send_line(1'b0, 0);
    drain_pipeline(tname);
  endtask

  // ============================================================
  // output collection and timeout
  // ============================================================

  task automatic take_output();
    out_pixel_t exp;
    logic       found;
    found = 1'b0;
    if (exp_q.size() == 0) begin
      $display("%s: pixel delivered while no pixel was expected", cur_test);
      stop_with_failure();
    end else if (!lossy) begin
      exp = exp_q.pop_front();
      check_pixel(cur_test, exp, out_pix);
    end else begin
      // skip the pixels that were dropped on overflow
      while (!found && exp_q.size() != 0) begin
        exp   = exp_q.pop_front();
        found = (exp.pix == out_pix.pix);
      end
      if (!found) begin
        $display("%s: delivered pixel %h is out of order", cur_test, out_pix.pix);
        stop_with_failure();
      end
    end
  endtask

  // transfer happens at the next rising edge
  always @(negedge VCLK) begin
    if (nRST && out_valid && out_ready)
      take_output();
  end

  always @(posedge VCLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  // a failing assertion in the bound checker ends the run too
  always @(posedge VCLK) begin
    if (n64_video_top_inst.n64_video_chk_inst.assert_failed === 1'b1) begin
      $display("%s: an assertion in the bound checker failed", cur_test);
      stop_with_failure();
    end
  end

  // ============================================================
  // test sequence
  // ============================================================

  initial begin
    nRST       = 1'b0;
    nVDSYNC    = 1'b1;
    d          = '0;
    out_ready  = 1'b0;
    seed       = 82;
    cycle_cnt  = 0;
    hold_ready = 1'b0;
    lossy      = 1'b0;
    cur_test   = "reset";
    m_pre      = '1;
    m_cur      = '1;
    m_field    = 1'b1;
    m_lcnt     = 2'b00;
    m_vinfo    = '{vdata_detected: 1'b0, palmode: 1'b0, n64_480i: 1'b1};
    m_prev_hs  = 1'b1;
    m_hpos     = '0;

    repeat (8) @(posedge VCLK);
    #1;
    nRST = 1'b1;
    check_vinfo("reset", m_vinfo, vinfo);

    // no vsync/hsync coincidence yet, colour stays blanked
    send_field("blank_before_detect", 5, 1'b0);
    send_field("detect", 5, 1'b1);

    // toggling field parity
    send_field("interlace", 5, 1'b0);
    send_field("interlace", 5, 1'b1);
    send_field("interlace", 5, 1'b0);
    send_field("interlace", 5, 1'b1);

    send_field("progressive", 5, 1'b1);
    send_field("progressive", 5, 1'b1);
    send_field("progressive", 5, 1'b1);

    // 7 and 5 line fields for the line count modulo 4
    send_field("ntsc_lines", 7, 1'b1);
    send_field("ntsc_lines", 7, 1'b1);
    send_field("pal_lines", 5, 1'b1);
    send_field("pal_lines", 5, 1'b1);

    // one last full pixel, then the bus goes quiet and the watchdog drops video presence
    cur_test = "video_loss";
    send_pixel(m_cur);
    repeat (16) drive_beat(1'b1, 7'h00);
    m_vinfo.vdata_detected = 1'b0;
    check_vinfo("video_loss", m_vinfo, vinfo);
    send_field("blank_after_loss", 5, 1'b0);
    send_field("redetect", 5, 1'b1);

    // sink stalls for two lines, more than the buffer holds
    cur_test = "overflow";
    if (overflow !== 1'b0) begin
      $display("overflow flag is set before any back-pressure");
      stop_with_failure();
    end
    lossy      = 1'b1;
    hold_ready = 1'b1;
    send_line(1'b0, 0);
    send_line(1'b0, 0);
    hold_ready = 1'b0;
    send_line(1'b0, 0);
    drain_pipeline("overflow");
    lossy = 1'b0;

    if (overflow !== 1'b1) begin
      $display("overflow flag did not rise after the sink stalled");
      stop_with_failure();
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

/* tb_n64_video_chk.sv */
// assertion checker for output handshake, fifo fill level and sticky overflow; bound into the top
`timescale 1ns/1ps

module tb_n64_video_chk (
  input logic                      VCLK,
  input logic                      nRST,
  input n64_video_pkg::out_pixel_t out_pix,
  input logic                      out_valid,
  input logic                      out_ready,
  input logic                      pix_valid,
  input logic                      ready,
  input logic                      fifo_valid,
  input logic                      fifo_ready,
  input logic                      overflow
);

  import n64_video_pkg::*;

  // words held between fifo input and fifo output stage
  int occ;
  // set by any failing assertion below, watched by the testbench
  logic assert_failed;

  initial assert_failed = 1'b0;

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST)
      occ <= 0;
    else
      occ <= occ + int'(pix_valid && ready) - int'(fifo_valid && fifo_ready);
  end

  // stalled output keeps valid and payload
  a_out_hold: assert property (@(posedge VCLK) disable iff (!nRST)
    out_valid && !out_ready |=> out_valid && $stable(out_pix))
    else begin
      assert_failed = 1'b1;
      $error("output pixel changed while the sink was stalling");
    end

  // memory plus output stage, a write on top of that means a write while full
  a_no_full_write: assert property (@(posedge VCLK) disable iff (!nRST)
    pix_valid && ready |-> occ <= FIFO_DEPTH)
    else begin
      assert_failed = 1'b1;
      $error("fifo accepted a write while full");
    end

  a_overflow_sticky: assert property (@(posedge VCLK) disable iff (!nRST)
    overflow |=> overflow)
    else begin
      assert_failed = 1'b1;
      $error("overflow flag fell without a reset");
    end

endmodule

bind n64_video_top tb_n64_video_chk n64_video_chk_inst (
  .VCLK       (VCLK),
  .nRST       (nRST),
  .out_pix    (out_pix),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .pix_valid  (pix_valid),
  .ready      (ready),
  .fifo_valid (fifo_valid),
  .fifo_ready (fifo_ready),
  .overflow   (overflow)
);

/* n64_video_top.sv */
// top level of the n64 video path: demux, vinfo extractor, pixel fifo and output formatter
`timescale 1ns/1ps

module n64_video_top (
  input  logic                      VCLK,
  input  logic                      nRST,
  input  logic                      nVDSYNC,
  input  n64_video_pkg::n64_data_t  d,
  output n64_video_pkg::out_pixel_t out_pix,
  output logic                      out_valid,
  input  logic                      out_ready,
  output n64_video_pkg::vinfo_t     vinfo,
  output logic                      overflow
);

  import n64_video_pkg::*;

  // demux to fifo
  pixel_t pix;
  logic   pix_valid;
  logic   ready;
  // sync history for the extractor
  sync_t  sync_pre;
  sync_t  sync_cur;
  // fifo to formatter
  pixel_t fifo_pix;
  logic   fifo_valid;
  logic   fifo_ready;

  n64_vdemux n64_vdemux_inst (
    .VCLK      (VCLK),
    .nRST      (nRST),
    .nVDSYNC   (nVDSYNC),
    .d         (d),
    .pix       (pix),
    .pix_valid (pix_valid),
    .ready     (ready),
    .sync_pre  (sync_pre),
    .sync_cur  (sync_cur),
    .overflow  (overflow)
  );

  n64_vinfo_ext n64_vinfo_ext_inst (
    .VCLK     (VCLK),
    .nRST     (nRST),
    .nVDSYNC  (nVDSYNC),
    .sync_pre (sync_pre),
    .sync_cur (sync_cur),
    .vinfo    (vinfo)
  );

  n64_pixel_fifo n64_pixel_fifo_inst (
    .VCLK     (VCLK),
    .nRST     (nRST),
    .wr_pix   (pix),
    .wr_valid (pix_valid),
    .wr_ready (ready),
    .rd_pix   (fifo_pix),
    .rd_valid (fifo_valid),
    .rd_ready (fifo_ready)
  );

  n64_vout_fmt n64_vout_fmt_inst (
    .VCLK      (VCLK),
    .nRST      (nRST),
    .in_pix    (fifo_pix),
    .in_valid  (fifo_valid),
    .in_ready  (fifo_ready),
    .vinfo     (vinfo),
    .out_pix   (out_pix),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

/* n64_vout_fmt.sv */
// consumer: one-entry output register with hpos counting and colour blanking when no video
`timescale 1ns/1ps

module n64_vout_fmt (
  input  logic                      VCLK,
  input  logic                      nRST,
  input  n64_video_pkg::pixel_t     in_pix,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  n64_video_pkg::vinfo_t     vinfo,
  output n64_video_pkg::out_pixel_t out_pix,
  output logic                      out_valid,
  input  logic                      out_ready
);

  import n64_video_pkg::*;

  logic   accept;
  logic   line_start;
  logic   prev_nhsync;
  hpos_t  hpos_q;
  hpos_t  hpos_nxt;
  pixel_t pix_fmt;

  // ============================================================
  // handshake
  // ============================================================

  // register empty or draining this cycle
  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  // ============================================================
  // horizontal position and blanking
  // ============================================================

  // falling nhsync between two accepted pixels opens a new line
  assign line_start = prev_nhsync && !in_pix.sync.nhsync;

  always_comb begin
    if (line_start)
      hpos_nxt = '0;
    else if (&hpos_q)
      hpos_nxt = hpos_q;
    else
      hpos_nxt = hpos_q + 1'b1;

    pix_fmt = in_pix;
    if (!vinfo.vdata_detected) begin
      pix_fmt.red   = '0;
      pix_fmt.green = '0;
      pix_fmt.blue  = '0;
    end
  end

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      out_valid   <= 1'b0;
      prev_nhsync <= 1'b1;
      hpos_q      <= '0;
    end else begin
      if (accept) begin
        out_valid   <= 1'b1;
        prev_nhsync <= in_pix.sync.nhsync;
        hpos_q      <= hpos_nxt;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // payload holds under back-pressure since it only loads on accept
  always_ff @(posedge VCLK) begin
    if (accept)
      out_pix <= '{pix: pix_fmt, hpos: hpos_nxt};
  end

endmodule

/* n64_pixel_fifo.sv */
// valid/ready pixel fifo with a registered show-ahead output between producer and consumer
`timescale 1ns/1ps

module n64_pixel_fifo (
  input  logic                  VCLK,
  input  logic                  nRST,
  input  n64_video_pkg::pixel_t wr_pix,
  input  logic                  wr_valid,
  output logic                  wr_ready,
  output n64_video_pkg::pixel_t rd_pix,
  output logic                  rd_valid,
  input  logic                  rd_ready
);

  import n64_video_pkg::*;

  pixel_t             mem [FIFO_DEPTH];
  logic [FIFO_AW:0]   wr_ptr;
  logic [FIFO_AW:0]   rd_ptr;
  logic               empty;
  logic               full;
  logic               wr_en;
  logic               load;
  logic               bypass;

  // extra pointer msb separates full from empty
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                 (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

  assign wr_ready = !full;
  assign wr_en    = wr_valid && wr_ready;
  // output stage free or being drained this cycle
  assign load     = !rd_valid || rd_ready;
  // empty buffer, incoming word goes straight to the output stage
  assign bypass   = load && empty && wr_en;

  always_ff @(posedge VCLK) begin
    if (wr_en && !bypass)
      mem[wr_ptr[FIFO_AW-1:0]] <= wr_pix;
    if (load && !empty)
      rd_pix <= mem[rd_ptr[FIFO_AW-1:0]];
    else if (bypass)
      rd_pix <= wr_pix;
  end

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      rd_valid <= 1'b0;
    end else begin
      if (wr_en && !bypass)
        wr_ptr <= wr_ptr + 1'b1;
      if (load) begin
        rd_valid <= !empty || wr_en;
        if (!empty)
          rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

/* n64_vinfo_ext.sv */
// derives video presence, pal/ntsc and 480i/240p from the sync nibbles of the demux
`timescale 1ns/1ps

module n64_vinfo_ext (
  input  logic                 VCLK,
  input  logic                 nRST,
  input  logic                 nVDSYNC,
  input  n64_video_pkg::sync_t sync_pre,
  input  n64_video_pkg::sync_t sync_cur,
  output n64_video_pkg::vinfo_t vinfo
);

  import n64_video_pkg::*;

  logic                  nvdsync_q;
  logic                  sync_upd;
  logic                  vsync_fall;
  logic                  hsync_fall;
  logic [DSCLK_W-1:0]    dsclk_cnt;
  logic [VCLK_CNT_W-1:0] vclk_cnt;
  logic [HCLK_CNT_W-1:0] hclk_cnt;
  logic                  field_id;
  logic [1:0]            line_cnt;

  // sync_cur is fresh exactly one cycle after a sync beat
  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST)
      nvdsync_q <= 1'b1;
    else
      nvdsync_q <= nVDSYNC;
  end

  assign sync_upd   = !nvdsync_q;
  assign vsync_fall = sync_upd && sync_pre.nvsync && !sync_cur.nvsync;
  assign hsync_fall = sync_upd && sync_pre.nhsync && !sync_cur.nhsync;

  // ============================================================
  // watchdog and video presence
  // ============================================================

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      dsclk_cnt            <= '0;
      vclk_cnt             <= '0;
      hclk_cnt             <= '0;
      vinfo.vdata_detected <= 1'b0;
    end else begin
      // any saturated counter means the bus went quiet
      if (&dsclk_cnt || &vclk_cnt || &hclk_cnt)
        vinfo.vdata_detected <= 1'b0;
      if (vsync_fall && hsync_fall)
        vinfo.vdata_detected <= 1'b1;

      if (!nVDSYNC)
        dsclk_cnt <= '0;
      else if (!(&dsclk_cnt))
        dsclk_cnt <= dsclk_cnt + 1'b1;

      // lines since vsync
      if (vsync_fall)
        vclk_cnt <= '0;
      else if (hsync_fall && !(&vclk_cnt))
        vclk_cnt <= vclk_cnt + 1'b1;

      if (hsync_fall)
        hclk_cnt <= '0;
      else if (!(&hclk_cnt))
        hclk_cnt <= hclk_cnt + 1'b1;
    end
  end

  // ============================================================
  // field parity and line count per field
  // ============================================================

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      field_id       <= 1'b1;
      vinfo.n64_480i <= 1'b1;
      line_cnt       <= 2'b00;
      vinfo.palmode  <= 1'b0;
    end else if (vsync_fall) begin
      // toggling parity between fields means interlaced
      field_id       <= hsync_fall;
      vinfo.n64_480i <= field_id ^ hsync_fall;
      // pal: count bit 1 low at field end
      vinfo.palmode  <= ~line_cnt[1];
      line_cnt       <= 2'b00;
    end else if (hsync_fall) begin
      line_cnt <= line_cnt + 2'd1;
    end
  end

endmodule

/* n64_vdemux.sv */
// producer: gathers sync/red/green/blue beats of the n64 bus into pixel structs, never stalls
`timescale 1ns/1ps

module n64_vdemux (
  input  logic                   VCLK,
  input  logic                   nRST,
  input  logic                   nVDSYNC,
  input  n64_video_pkg::n64_data_t d,
  output n64_video_pkg::pixel_t  pix,
  output logic                   pix_valid,
  input  logic                   ready,
  output n64_video_pkg::sync_t   sync_pre,
  output n64_video_pkg::sync_t   sync_cur,
  output logic                   overflow
);

  import n64_video_pkg::*;

  demux_state_t state;

  // partial pixel, colour beats wait here until blue shows up
  color_t red_r;
  color_t green_r;

  // ============================================================
  // beat tracking fsm and sync history
  // ============================================================

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      state     <= wait_sync;
      pix_valid <= 1'b0;
      // idle bus has all sync lines high
      sync_cur  <= '1;
      sync_pre  <= '1;
    end else begin
      pix_valid <= 1'b0;
      if (!nVDSYNC) begin
        // a sync beat always restarts the pixel, early ones drop the partial data
        sync_pre <= sync_cur;
        sync_cur <= sync_t'(d[3:0]);
        state    <= get_red;
      end else begin
        case (state)
          get_red:   state <= get_green;
          get_green: state <= get_blue;
          get_blue: begin
            state     <= wait_sync;
            pix_valid <= 1'b1;
          end
          // stray colour beats without a preceding sync are ignored
          default:   state <= wait_sync;
        endcase
      end
    end
  end

  // ============================================================
  // payload capture
  // ============================================================

  always_ff @(posedge VCLK) begin
    if (nVDSYNC && state == get_red)
      red_r <= d;
    if (nVDSYNC && state == get_green)
      green_r <= d;
    if (nVDSYNC && state == get_blue)
      pix <= '{sync: sync_cur, red: red_r, green: green_r, blue: d};
  end

  // console cannot be stalled, a refused pixel is lost
  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST)
      overflow <= 1'b0;
    else if (pix_valid && !ready)
      overflow <= 1'b1;
  end

endmodule

/* n64_video_pkg.sv */
// shared widths, structs and constants for the n64 video path; import into every rtl module
package n64_video_pkg;

  // ============================================================
  // bus and colour widths
  // ============================================================

  // one beat of the 7-bit digital video bus
  typedef logic [6:0] n64_data_t;
  // n64 colour components are 7 bits deep
  typedef logic [6:0] color_t;
  // horizontal pixel position inside a line
  typedef logic [9:0] hpos_t;

  // ============================================================
  // structs
  // ============================================================

  // field order follows D[3:0] of the sync beat, nvsync is the msb
  typedef struct packed {
    logic nvsync;
    logic nclamp;
    logic nhsync;
    logic ncsync;
  } sync_t;

  // one assembled pixel, 25 bits
  typedef struct packed {
    sync_t  sync;
    color_t red;
    color_t green;
    color_t blue;
  } pixel_t;

  typedef struct packed {
    logic vdata_detected;
    logic palmode;
    logic n64_480i;
  } vinfo_t;

  typedef struct packed {
    pixel_t pix;
    hpos_t  hpos;
  } out_pixel_t;

  // demux beat tracker
  typedef enum logic [1:0] {
    wait_sync,
    get_red,
    get_green,
    get_blue
  } demux_state_t;

  // ============================================================
  // sizes
  // ============================================================

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;

  // saturating watchdog counter widths
  localparam int DSCLK_W    = 3;
  localparam int VCLK_CNT_W = 9;
  localparam int HCLK_CNT_W = 12;

endpackage
